//--- decode_cfg.svh
/*
 * Build-time configuration of the decode stage.
 * Included by the package and by every module that needs a width,
 * the reset vector or the M-extension switch.
 */

`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// data and address width of the core
`define XLEN 32

// register file has 32 entries
`define REGADDR_W 5

// PC value out of reset, must be word-aligned
`define RESET_VECTOR 32'h0000_0040

// set to 0 to treat MUL/DIV/REM encodings as illegal
`define HAS_EXT_M 1

`endif

//--- decode_pkg.sv
/*
 * Types shared by the decode stage and its testbench.
 * Holds the width typedefs, the control encodings seen by execute
 * and the packed bundles that travel between fetch, decode and execute.
 */

`include "decode_cfg.svh"

package decode_pkg;

	typedef logic [`XLEN-1:0]      word_t;
	typedef logic [`XLEN-1:0]      addr_t;
	typedef logic [`REGADDR_W-1:0] regaddr_t;

	// number of valid halfwords in the instruction register
	typedef logic [1:0]            hw_cnt_t;

	// ------------------------------
	// encodings for execute
	// ------------------------------

	typedef enum logic [4:0] {
		ALUOP_ADD    = 5'h00,
		ALUOP_SUB    = 5'h01,
		ALUOP_LT     = 5'h02,
		ALUOP_LTU    = 5'h03,
		ALUOP_AND    = 5'h04,
		ALUOP_OR     = 5'h05,
		ALUOP_XOR    = 5'h06,
		ALUOP_SLL    = 5'h07,
		ALUOP_SRL    = 5'h08,
		ALUOP_SRA    = 5'h09,
		ALUOP_RS2    = 5'h0a,
		ALUOP_MULDIV = 5'h0b
	} aluop_e;

	typedef enum logic [3:0] {
		MEMOP_NONE = 4'h0,
		MEMOP_LB   = 4'h1,
		MEMOP_LH   = 4'h2,
		MEMOP_LW   = 4'h3,
		MEMOP_LBU  = 4'h4,
		MEMOP_LHU  = 4'h5,
		MEMOP_SB   = 4'h6,
		MEMOP_SH   = 4'h7,
		MEMOP_SW   = 4'h8
	} memop_e;

	// ordered to match funct3 of the M extension
	typedef enum logic [2:0] {
		M_OP_MUL    = 3'h0,
		M_OP_MULH   = 3'h1,
		M_OP_MULHSU = 3'h2,
		M_OP_MULHU  = 3'h3,
		M_OP_DIV    = 3'h4,
		M_OP_DIVU   = 3'h5,
		M_OP_REM    = 3'h6,
		M_OP_REMU   = 3'h7
	} mulop_e;

	// branch taken when the ALU result matches the condition
	typedef enum logic [1:0] {
		BCOND_NEVER  = 2'h0,
		BCOND_ALWAYS = 2'h1,
		BCOND_ZERO   = 2'h2,
		BCOND_NZERO  = 2'h3
	} bcond_e;

	typedef enum logic [2:0] {
		EXCEPT_NONE          = 3'h0,
		EXCEPT_ECALL         = 3'h1,
		EXCEPT_EBREAK        = 3'h2,
		EXCEPT_INSTR_ILLEGAL = 3'h3,
		EXCEPT_INSTR_FAULT   = 3'h4
	} except_e;

	typedef enum logic {ALUSRCA_RS1 = 1'b0, ALUSRCA_PC  = 1'b1} alusrc_a_e;
	typedef enum logic {ALUSRCB_RS2 = 1'b0, ALUSRCB_IMM = 1'b1} alusrc_b_e;

	// ------------------------------
	// bundles
	// ------------------------------

	typedef struct packed {
		word_t imm_i;
		word_t imm_s;
		word_t imm_b;
		word_t imm_u;
		word_t imm_j;
	} imm_set_t;

	// err has one bit per halfword of instr
	typedef struct packed {
		word_t      instr;
		hw_cnt_t    vld;
		logic [1:0] err;
	} fetch_t;

	typedef struct packed {
		logic  now;
		addr_t target;
	} jump_t;

	typedef struct packed {
		regaddr_t  rs1;
		regaddr_t  rs2;
		regaddr_t  rd;
		word_t     imm;
		alusrc_a_e alusrc_a;
		alusrc_b_e alusrc_b;
		aluop_e    aluop;
		memop_e    memop;
		mulop_e    mulop;
		bcond_e    branchcond;
		addr_t     addr_offs;
		logic      addr_is_regoffs;
		except_e   except;
	} dec_ctrl_t;

endpackage

//--- imm_gen.sv
/*
 * Immediate extraction for 32-bit RISC-V instructions.
 * Produces all five formats in parallel; the decoder picks the one
 * that belongs to the opcode. Purely combinational.
 */

module imm_gen
	import decode_pkg::*;
(
	input  word_t    instr_i,
	output imm_set_t imms_o
);

	logic sgn;

	// bit 31 is the sign for every format
	assign sgn = instr_i[31];

	// loads, JALR and the register-immediate ALU forms
	assign imms_o.imm_i = {{21{sgn}}, instr_i[30:20]};

	// stores split the offset around rd
	assign imms_o.imm_s = {{21{sgn}}, instr_i[30:25], instr_i[11:7]};

	// branch offsets are halfword multiples so bit 0 is always clear
	assign imms_o.imm_b = {
		{20{sgn}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0
	};

	// upper immediate for LUI and AUIPC
	assign imms_o.imm_u = {instr_i[31:12], 12'h000};

	// JAL has the widest range, again with a zero LSB
	assign imms_o.imm_j = {
		{12{sgn}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0
	};

endmodule

//--- instr_decode.sv
/*
 * Instruction decoder for RV32I with optional M extension.
 * First maps the instruction onto raw execute controls, then forces a
 * harmless bundle when the instruction register is starved, the fetch
 * faulted or the encoding is illegal. Purely combinational.
 */

`include "decode_cfg.svh"

module instr_decode
	import decode_pkg::*;
(
	input  word_t     instr_i,
	input  imm_set_t  imms_i,
	input  logic      starved_i,
	input  logic      bus_fault_i,
	output dec_ctrl_t ctrl_o
);

	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_FENCE  = 7'b0001111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam word_t INSTR_ECALL  = 32'h0000_0073;
	localparam word_t INSTR_EBREAK = 32'h0010_0073;

	// link value for JAL and JALR is PC plus one instruction
	localparam word_t LINK_OFFS = 32'h0000_0004;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	dec_ctrl_t  raw;
	logic       illegal;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	// ------------------------------
	// raw decode
	// ------------------------------

	always_comb begin
		raw                 = '0;
		raw.rs1             = instr_i[19:15];
		raw.rs2             = instr_i[24:20];
		raw.rd              = instr_i[11:7];
		raw.imm             = imms_i.imm_i;
		raw.alusrc_a        = ALUSRCA_RS1;
		raw.alusrc_b        = ALUSRCB_RS2;
		raw.aluop           = ALUOP_ADD;
		raw.memop           = MEMOP_NONE;
		raw.mulop           = M_OP_MUL;
		raw.branchcond      = BCOND_NEVER;
		raw.addr_offs       = '0;
		raw.addr_is_regoffs = 1'b0;
		raw.except          = EXCEPT_NONE;
		illegal             = 1'b0;

		case (opcode)
		OPC_LUI: begin
			raw.rs1      = '0;
			raw.rs2      = '0;
			raw.imm      = imms_i.imm_u;
			raw.alusrc_b = ALUSRCB_IMM;
			raw.aluop    = ALUOP_RS2;
		end
		OPC_AUIPC: begin
			raw.rs1      = '0;
			raw.rs2      = '0;
			raw.imm      = imms_i.imm_u;
			raw.alusrc_a = ALUSRCA_PC;
			raw.alusrc_b = ALUSRCB_IMM;
		end
		OPC_JAL: begin
			raw.rs1        = '0;
			raw.rs2        = '0;
			raw.imm        = LINK_OFFS;
			raw.alusrc_a   = ALUSRCA_PC;
			raw.alusrc_b   = ALUSRCB_IMM;
			raw.branchcond = BCOND_ALWAYS;
			raw.addr_offs  = imms_i.imm_j;
		end
		OPC_JALR: begin
			illegal             = (funct3 != 3'b000);
			raw.rs2             = '0;
			raw.imm             = LINK_OFFS;
			raw.alusrc_a        = ALUSRCA_PC;
			raw.alusrc_b        = ALUSRCB_IMM;
			raw.branchcond      = BCOND_ALWAYS;
			raw.addr_offs       = imms_i.imm_i;
			raw.addr_is_regoffs = 1'b1;
		end
		OPC_BRANCH: begin
			raw.rd        = '0;
			raw.addr_offs = imms_i.imm_b;
			// BGE and BGEU take the inverted condition of BLT and BLTU
			case (funct3)
			3'b000: begin
				raw.aluop      = ALUOP_SUB;
				raw.branchcond = BCOND_ZERO;
			end
			3'b001: begin
				raw.aluop      = ALUOP_SUB;
				raw.branchcond = BCOND_NZERO;
			end
			3'b100: begin
				raw.aluop      = ALUOP_LT;
				raw.branchcond = BCOND_NZERO;
			end
			3'b101: begin
				raw.aluop      = ALUOP_LT;
				raw.branchcond = BCOND_ZERO;
			end
			3'b110: begin
				raw.aluop      = ALUOP_LTU;
				raw.branchcond = BCOND_NZERO;
			end
			3'b111: begin
				raw.aluop      = ALUOP_LTU;
				raw.branchcond = BCOND_ZERO;
			end
			default: illegal = 1'b1;
			endcase
		end
		OPC_LOAD: begin
			raw.rs2             = '0;
			raw.addr_offs       = imms_i.imm_i;
			raw.addr_is_regoffs = 1'b1;
			case (funct3)
			3'b000:  raw.memop = MEMOP_LB;
			3'b001:  raw.memop = MEMOP_LH;
			3'b010:  raw.memop = MEMOP_LW;
			3'b100:  raw.memop = MEMOP_LBU;
			3'b101:  raw.memop = MEMOP_LHU;
			default: illegal   = 1'b1;
			endcase
		end
		OPC_STORE: begin
			// ALU passes rs2 through as the store data
			raw.rd              = '0;
			raw.aluop           = ALUOP_RS2;
			raw.addr_offs       = imms_i.imm_s;
			raw.addr_is_regoffs = 1'b1;
			case (funct3)
			3'b000:  raw.memop = MEMOP_SB;
			3'b001:  raw.memop = MEMOP_SH;
			3'b010:  raw.memop = MEMOP_SW;
			default: illegal   = 1'b1;
			endcase
		end
		OPC_OP_IMM: begin
			raw.rs2      = '0;
			raw.alusrc_b = ALUSRCB_IMM;
			case (funct3)
			3'b000: raw.aluop = ALUOP_ADD;
			3'b010: raw.aluop = ALUOP_LT;
			3'b011: raw.aluop = ALUOP_LTU;
			3'b100: raw.aluop = ALUOP_XOR;
			3'b110: raw.aluop = ALUOP_OR;
			3'b111: raw.aluop = ALUOP_AND;
			3'b001: begin
				raw.aluop = ALUOP_SLL;
				illegal   = (funct7 != 7'b0000000);
			end
			default: begin
				// for a right shift funct7 picks logical or arithmetic
				raw.aluop = funct7[5] ? ALUOP_SRA : ALUOP_SRL;
				illegal   = ({funct7[6], funct7[4:0]} != 6'b000000);
			end
			endcase
		end
		OPC_OP: begin
			case (funct7)
			7'b0000000: begin
				case (funct3)
				3'b000:  raw.aluop = ALUOP_ADD;
				3'b001:  raw.aluop = ALUOP_SLL;
				3'b010:  raw.aluop = ALUOP_LT;
				3'b011:  raw.aluop = ALUOP_LTU;
				3'b100:  raw.aluop = ALUOP_XOR;
				3'b101:  raw.aluop = ALUOP_SRL;
				3'b110:  raw.aluop = ALUOP_OR;
				default: raw.aluop = ALUOP_AND;
				endcase
			end
			7'b0100000: begin
				case (funct3)
				3'b000:  raw.aluop = ALUOP_SUB;
				3'b101:  raw.aluop = ALUOP_SRA;
				default: illegal   = 1'b1;
				endcase
			end
			7'b0000001: begin
				if (`HAS_EXT_M != 0) begin
					raw.aluop = ALUOP_MULDIV;
					raw.mulop = mulop_e'(funct3);
				end else begin
					illegal = 1'b1;
				end
			end
			default: illegal = 1'b1;
			endcase
		end
		OPC_FENCE: begin
			// single-issue in-order core, so FENCE retires as ADD x0, x0, x0
			illegal = (funct3 != 3'b000);
			raw.rs1 = '0;
			raw.rs2 = '0;
			raw.rd  = '0;
		end
		OPC_SYSTEM: begin
			raw.rs1 = '0;
			raw.rs2 = '0;
			raw.rd  = '0;
			if (instr_i == INSTR_ECALL) begin
				raw.except = EXCEPT_ECALL;
			end else if (instr_i == INSTR_EBREAK) begin
				raw.except = EXCEPT_EBREAK;
			end else begin
				illegal = 1'b1;
			end
		end
		default: illegal = 1'b1;
		endcase
	end

	// ------------------------------
	// gating
	// ------------------------------

	// a killed instruction must not touch registers, memory or the PC
	always_comb begin
		ctrl_o = raw;
		if (starved_i || bus_fault_i || illegal) begin
			ctrl_o.rs1        = '0;
			ctrl_o.rs2        = '0;
			ctrl_o.rd         = '0;
			ctrl_o.memop      = MEMOP_NONE;
			ctrl_o.branchcond = BCOND_NEVER;
			if (bus_fault_i) begin
				ctrl_o.except = EXCEPT_INSTR_FAULT;
			end else if (!starved_i) begin
				ctrl_o.except = EXCEPT_INSTR_ILLEGAL;
			end else begin
				ctrl_o.except = EXCEPT_NONE;
			end
		end
	end

endmodule

//--- pc_ctrl.sv
/*
 * Program counter and instruction-register control.
 * Flags starvation and fetch bus faults, tells fetch how many halfwords
 * were consumed, and holds the PC of the instruction in decode.
 */

`include "decode_cfg.svh"

module pc_ctrl
	import decode_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  fetch_t  fetch_i,
	input  logic    x_stall_i,
	input  jump_t   jump_i,
	output hw_cnt_t cir_use_o,
	output logic    starved_o,
	output logic    bus_fault_o,
	output addr_t   pc_o
);

	addr_t pc_q;
	logic  consume;

	// only whole 32-bit instructions are decoded
	assign starved_o = (fetch_i.vld < 2'd2);

	// an error bit counts only for a halfword that is actually present
	assign bus_fault_o = (fetch_i.err[0] && (fetch_i.vld >= 2'd1)) ||
		(fetch_i.err[1] && (fetch_i.vld >= 2'd2));

	assign consume   = !starved_o && !x_stall_i;
	assign cir_use_o = consume ? 2'd2 : 2'd0;

	// ------------------------------
	// PC register
	// ------------------------------

	// a jump wins over a stall, the target is what decode sees next
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q <= `RESET_VECTOR;
		end else if (jump_i.now) begin
			pc_q <= jump_i.target;
		end else if (consume) begin
			pc_q <= pc_q + addr_t'(4);
		end
	end

	assign pc_o = pc_q;

	// fetch must never be told to drop halfwords it has not delivered
	a_no_use_when_starved: assert property (
		@(posedge clk) disable iff (!rst_n)
		(fetch_i.vld < 2'd2) |-> (cir_use_o == 2'd0)
	) else $error("cir_use_o nonzero with fewer than two valid halfwords");

	// alignment is kept from cycle to cycle unless a misaligned target comes in
	a_pc_aligned: assert property (
		@(posedge clk) disable iff (!rst_n)
		((pc_q[1:0] == 2'b00) && !(jump_i.now && (jump_i.target[1:0] != 2'b00)))
			|=> (pc_q[1:0] == 2'b00)
	) else $error("PC lost word alignment");

endmodule

//--- decode_stage.sv
/*
 * Decode stage top level.
 * Sits between fetch and execute: takes the instruction register from
 * fetch, returns the halfword use count, and hands execute a control
 * bundle and the PC of the instruction being decoded.
 */

module decode_stage
	import decode_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	// fetch side
	input  fetch_t    fetch_i,
	output hw_cnt_t   cir_use_o,

	// execute and frontend side
	input  logic      x_stall_i,
	input  jump_t     jump_i,
	output logic      d_starved_o,
	output addr_t     d_pc_o,
	output dec_ctrl_t d_ctrl_o
);

	logic     starved;
	logic     bus_fault;
	imm_set_t imms;

	pc_ctrl u_pc_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.fetch_i     (fetch_i),
		.x_stall_i   (x_stall_i),
		.jump_i      (jump_i),
		.cir_use_o   (cir_use_o),
		.starved_o   (starved),
		.bus_fault_o (bus_fault),
		.pc_o        (d_pc_o)
	);

	imm_gen u_imm_gen (
		.instr_i (fetch_i.instr),
		.imms_o  (imms)
	);

	// the bundle stays valid under stall so execute can finish the instruction
	instr_decode u_instr_decode (
		.instr_i     (fetch_i.instr),
		.imms_i      (imms),
		.starved_i   (starved),
		.bus_fault_i (bus_fault),
		.ctrl_o      (d_ctrl_o)
	);

	assign d_starved_o = starved;

endmodule

//--- tb_decode_model.svh
/*
 * Reference model of the decode stage for the testbench.
 * Included inside the testbench module. Gives the expected control
 * bundle for one fetch word, the expected use count and the PC
 * after one rising clock edge.
 */

`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

localparam logic [6:0] OPCODE_LUI    = 7'h37;
localparam logic [6:0] OPCODE_AUIPC  = 7'h17;
localparam logic [6:0] OPCODE_JAL    = 7'h6f;
localparam logic [6:0] OPCODE_JALR   = 7'h67;
localparam logic [6:0] OPCODE_BRANCH = 7'h63;
localparam logic [6:0] OPCODE_LOAD   = 7'h03;
localparam logic [6:0] OPCODE_STORE  = 7'h23;
localparam logic [6:0] OPCODE_OPIMM  = 7'h13;
localparam logic [6:0] OPCODE_OPREG  = 7'h33;
localparam logic [6:0] OPCODE_FENCE  = 7'h0f;
localparam logic [6:0] OPCODE_SYSTEM = 7'h73;

// ------------------------------
// immediates
// ------------------------------

function automatic word_t i_imm(input word_t w);
	return {{20{w[31]}}, w[31:20]};
endfunction

function automatic word_t s_imm(input word_t w);
	return {{20{w[31]}}, w[31:25], w[11:7]};
endfunction

function automatic word_t b_imm(input word_t w);
	return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
endfunction

function automatic word_t u_imm(input word_t w);
	return {w[31:12], 12'h000};
endfunction

function automatic word_t j_imm(input word_t w);
	return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
endfunction

// shared ALU table of the register and immediate forms
function automatic aluop_e funct3_aluop(input logic [2:0] f3, input logic arith);
	case (f3)
	3'd0:    return ALUOP_ADD;
	3'd1:    return ALUOP_SLL;
	3'd2:    return ALUOP_LT;
	3'd3:    return ALUOP_LTU;
	3'd4:    return ALUOP_XOR;
	3'd5:    return arith ? ALUOP_SRA : ALUOP_SRL;
	3'd6:    return ALUOP_OR;
	default: return ALUOP_AND;
	endcase
endfunction

// ------------------------------
// control bundle
// ------------------------------

function automatic dec_ctrl_t expected_ctrl(input fetch_t f);
	dec_ctrl_t  c;
	word_t      w;
	logic [6:0] opc;
	logic [2:0] f3;
	logic [6:0] f7;
	logic       bad;
	logic       fault;
	logic       starved;
	w   = f.instr;
	opc = w[6:0];
	f3  = w[14:12];
	f7  = w[31:25];
	bad = 1'b0;
	c   = '0;

	// register fields a format does not use are zero
	c.rs1 = (opc inside {OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL, OPCODE_FENCE,
		OPCODE_SYSTEM}) ? 5'd0 : w[19:15];
	c.rs2 = (opc inside {OPCODE_OPREG, OPCODE_STORE, OPCODE_BRANCH}) ? w[24:20] : 5'd0;
	c.rd  = (opc inside {OPCODE_STORE, OPCODE_BRANCH, OPCODE_FENCE,
		OPCODE_SYSTEM}) ? 5'd0 : w[11:7];
	c.imm = (opc inside {OPCODE_LUI, OPCODE_AUIPC}) ? u_imm(w) :
		((opc inside {OPCODE_JAL, OPCODE_JALR}) ? 32'd4 : i_imm(w));
	c.alusrc_a = (opc inside {OPCODE_AUIPC, OPCODE_JAL, OPCODE_JALR}) ?
		ALUSRCA_PC : ALUSRCA_RS1;
	c.alusrc_b = (opc inside {OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL, OPCODE_JALR,
		OPCODE_OPIMM}) ? ALUSRCB_IMM : ALUSRCB_RS2;
	c.aluop = (opc inside {OPCODE_LUI, OPCODE_STORE}) ? ALUOP_RS2 : ALUOP_ADD;
	c.memop = MEMOP_NONE;
	c.mulop = M_OP_MUL;
	c.branchcond = (opc inside {OPCODE_JAL, OPCODE_JALR}) ? BCOND_ALWAYS : BCOND_NEVER;
	c.addr_is_regoffs = (opc inside {OPCODE_JALR, OPCODE_LOAD, OPCODE_STORE});
	c.except = EXCEPT_NONE;

	case (opc)
	OPCODE_LUI, OPCODE_AUIPC: bad = 1'b0;
	OPCODE_JAL: c.addr_offs = j_imm(w);
	OPCODE_JALR: begin
		bad         = (f3 != 3'd0);
		c.addr_offs = i_imm(w);
	end
	OPCODE_BRANCH: begin
		bad         = (f3[2:1] == 2'b01);
		c.addr_offs = b_imm(w);
		if (!bad) begin
			c.aluop      = !f3[2] ? ALUOP_SUB : (f3[1] ? ALUOP_LTU : ALUOP_LT);
			// odd funct3 inverts the sense for BEQ/BNE, even for the compares
			c.branchcond = (f3[0] ^ f3[2]) ? BCOND_NZERO : BCOND_ZERO;
		end
	end
	OPCODE_LOAD: begin
		c.addr_offs = i_imm(w);
		case (f3)
		3'd0:    c.memop = MEMOP_LB;
		3'd1:    c.memop = MEMOP_LH;
		3'd2:    c.memop = MEMOP_LW;
		3'd4:    c.memop = MEMOP_LBU;
		3'd5:    c.memop = MEMOP_LHU;
		default: bad = 1'b1;
		endcase
	end
	OPCODE_STORE: begin
		c.addr_offs = s_imm(w);
		case (f3)
		3'd0:    c.memop = MEMOP_SB;
		3'd1:    c.memop = MEMOP_SH;
		3'd2:    c.memop = MEMOP_SW;
		default: bad = 1'b1;
		endcase
	end
	OPCODE_OPIMM: begin
		c.aluop = funct3_aluop(f3, f7[5]);
		if (f3 == 3'd1) begin
			bad = (f7 != 7'h00);
		end else if (f3 == 3'd5) begin
			bad = ((f7 & 7'h5f) != 7'h00);
		end
	end
	OPCODE_OPREG: begin
		if (f7 == 7'h00) begin
			c.aluop = funct3_aluop(f3, 1'b0);
		end else if (f7 == 7'h20 && f3 == 3'd0) begin
			c.aluop = ALUOP_SUB;
		end else if (f7 == 7'h20 && f3 == 3'd5) begin
			c.aluop = ALUOP_SRA;
		end else if (f7 == 7'h01) begin
			bad = (`HAS_EXT_M == 0);
			if (!bad) begin
				c.aluop = ALUOP_MULDIV;
				c.mulop = mulop_e'(f3);
			end
		end else begin
			bad = 1'b1;
		end
	end
	OPCODE_FENCE: bad = (f3 != 3'd0);
	OPCODE_SYSTEM: begin
		if (w == 32'h0000_0073) begin
			c.except = EXCEPT_ECALL;
		end else if (w == 32'h0010_0073) begin
			c.except = EXCEPT_EBREAK;
		end else begin
			bad = 1'b1;
		end
	end
	default: bad = 1'b1;
	endcase

	// a dead instruction keeps its ALU fields but loses every side effect
	fault   = (f.err[0] && f.vld >= 2'd1) || (f.err[1] && f.vld >= 2'd2);
	starved = (f.vld < 2'd2);
	if (starved || fault || bad) begin
		c.rs1        = '0;
		c.rs2        = '0;
		c.rd         = '0;
		c.memop      = MEMOP_NONE;
		c.branchcond = BCOND_NEVER;
		c.except     = fault ? EXCEPT_INSTR_FAULT :
			(!starved ? EXCEPT_INSTR_ILLEGAL : EXCEPT_NONE);
	end
	return c;
endfunction

// ------------------------------
// handshake and PC
// ------------------------------

function automatic hw_cnt_t use_count(input fetch_t f, input logic stall);
	return (f.vld >= 2'd2 && !stall) ? 2'd2 : 2'd0;
endfunction

function automatic addr_t next_pc(input addr_t pc, input fetch_t f, input logic stall,
	input jump_t j);
	if (j.now) begin
		return j.target;
	end
	if (f.vld >= 2'd2 && !stall) begin
		return pc + 32'd4;
	end
	return pc;
endfunction

`endif

//--- tb_decode.sv
/*
 * Random testbench for the decode stage.
 * Drives fetch words, stalls and jumps on the falling edge and checks
 * the control bundle, use count, starved flag and PC against the model
 * in the included header. Build with sim.f, for example through run.sh.
 */

`include "decode_cfg.svh"

module tb_decode
	import decode_pkg::*;
();

	localparam int NUM_CYCLES     = 2000;
	localparam int RESET_CYCLES   = 2;
	// reset plus the random cycles with a wide margin
	localparam int TIMEOUT_CYCLES = NUM_CYCLES + RESET_CYCLES + 998;

	logic      clk;
	logic      rst_n;
	fetch_t    fetch;
	logic      x_stall;
	jump_t     jump;
	hw_cnt_t   cir_use;
	logic      d_starved;
	addr_t     d_pc;
	dec_ctrl_t d_ctrl;
	addr_t     exp_pc;
	string     cls_name;
	int        cycle_cnt = 0;

	`include "tb_decode_model.svh"

	decode_stage dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.fetch_i     (fetch),
		.cir_use_o   (cir_use),
		.x_stall_i   (x_stall),
		.jump_i      (jump),
		.d_starved_o (d_starved),
		.d_pc_o      (d_pc),
		.d_ctrl_o    (d_ctrl)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			abort_run("timeout: the run went past its cycle limit");
		end
	end

	// ------------------------------
	// reporting and compares
	// ------------------------------

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("tests failed");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_ctrl(input string name, input dec_ctrl_t exp, input dec_ctrl_t act);
		if (act !== exp) begin
			abort_run($sformatf("error %s: expected ctrl %h, actual ctrl %h", name, exp, act));
		end
	endtask

	task automatic check_pc(input string name, input addr_t exp, input addr_t act);
		if (act !== exp) begin
			abort_run($sformatf("error %s: expected pc %h, actual pc %h", name, exp, act));
		end
	endtask

	task automatic check_use(input string name, input hw_cnt_t exp, input hw_cnt_t act);
		if (act !== exp) begin
			abort_run($sformatf("error %s: expected use %0d, actual use %0d", name, exp, act));
		end
	endtask

	task automatic check_starved(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			abort_run($sformatf("error %s: expected starved %b, actual starved %b",
				name, exp, act));
		end
	endtask

	// ------------------------------
	// stimulus
	// ------------------------------

	// picks an instruction class and fills the remaining fields at random
	task automatic random_instr(output word_t w, output string name);
		word_t       r;
		int unsigned cls;
		logic [6:0]  f7;
		r   = $urandom();
		cls = $urandom() % 12;
		case (cls)
		0: begin
			f7   = r[0] ? 7'h00 : (r[1] ? 7'h20 : 7'h01);
			w    = {f7, r[24:7], OPCODE_OPREG};
			name = "alu_reg";
		end
		1: begin
			w = {r[31:7], OPCODE_OPIMM};
			// mostly legal shift encodings
			if (w[13:12] == 2'b01 && r[0]) begin
				w[31:25] = {1'b0, r[1], 5'b00000};
			end
			name = "alu_imm";
		end
		2: begin
			w    = {r[31:7], OPCODE_LUI};
			name = "lui";
		end
		3: begin
			w    = {r[31:7], OPCODE_AUIPC};
			name = "auipc";
		end
		4: begin
			w    = {r[31:7], OPCODE_LOAD};
			name = "load";
		end
		5: begin
			w    = {r[31:7], OPCODE_STORE};
			name = "store";
		end
		6: begin
			w    = {r[31:7], OPCODE_BRANCH};
			name = "branch";
		end
		7: begin
			w    = {r[31:7], OPCODE_JAL};
			name = "jal";
		end
		8: begin
			w = {r[31:7], OPCODE_JALR};
			if (r[0]) begin
				w[14:12] = 3'b000;
			end
			name = "jalr";
		end
		9: begin
			w = {r[31:7], OPCODE_FENCE};
			if (r[0]) begin
				w[14:12] = 3'b000;
			end
			name = "fence";
		end
		10: begin
			w = r[0] ? 32'h0000_0073 : 32'h0010_0073;
			if (r[1] && r[2]) begin
				w = {r[31:7], OPCODE_SYSTEM};
			end
			name = "system";
		end
		default: begin
			w    = r;
			name = "random_word";
		end
		endcase
	endtask

	task automatic drive_inputs();
		word_t       w;
		int unsigned roll;
		random_instr(w, cls_name);
		fetch.instr = w;
		roll        = $urandom() % 20;
		fetch.vld   = (roll < 17) ? 2'd2 : hw_cnt_t'(roll % 2);
		fetch.err   = (($urandom() % 20) == 0) ? 2'(1 + $urandom() % 3) : 2'b00;
		x_stall     = (($urandom() % 5) == 0);
		jump.now    = (($urandom() % 20) == 0);
		jump.target = $urandom() & 32'hffff_fffc;
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------

	initial begin
		string tname;
		void'($urandom(32'h7b5d));
		rst_n    = 1'b0;
		fetch    = '0;
		x_stall  = 1'b0;
		jump     = '0;
		cls_name = "reset";

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		// still in reset, so the bundle is the starved one
		check_pc("reset", `RESET_VECTOR, d_pc);
		check_use("reset", 2'd0, cir_use);
		check_starved("reset", 1'b1, d_starved);
		check_ctrl("reset", expected_ctrl(fetch), d_ctrl);
		rst_n  = 1'b1;
		exp_pc = `RESET_VECTOR;

		for (int i = 0; i < NUM_CYCLES; i++) begin
			drive_inputs();
			@(negedge clk);
			tname = $sformatf("%s cycle %0d", cls_name, i);
			check_ctrl(tname, expected_ctrl(fetch), d_ctrl);
			check_use(tname, use_count(fetch, x_stall), cir_use);
			check_starved(tname, fetch.vld < 2'd2, d_starved);
			// the edge in between has already applied these inputs to the PC
			exp_pc = next_pc(exp_pc, fetch, x_stall, jump);
			check_pc(tname, exp_pc, d_pc);
		end

		$display("all tests passed");
		$finish;
	end

endmodule

//--- sim.f
+incdir+.
decode_pkg.sv
imm_gen.sv
instr_decode.sv
pc_ctrl.sv
decode_stage.sv
tb_decode.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_decode -o tb_decode

# keep the output of a failing run so the error line is visible
output=$(./obj_dir/tb_decode 2>&1) || true
echo "$output"

if grep -q "all tests passed" <<< "$output"; then
	exit 0
fi
exit 1
